//--- mmio_bridge_settings.svh
`ifndef MMIO_BRIDGE_SETTINGS_SVH
`define MMIO_BRIDGE_SETTINGS_SVH

// Bus and network widths
`define MMIO_PADDR_WIDTH   32
`define MMIO_DATA_WIDTH    32
`define MMIO_EPA_WIDTH     16
`define MMIO_X_WIDTH       4
`define MMIO_Y_WIDTH       4
`define MMIO_REG_ID_WIDTH  5

// Transactions in flight toward the mesh
`define MMIO_OUTSTANDING   4

// Address regions taken from paddr bits 31:30
`define MMIO_REGION_TILE   2'b11
`define MMIO_REGION_CACHE  2'b10

// Device windows seen by inbound requests
`define MMIO_DEV_HOST_BASE    32'h0010_0000
`define MMIO_DEV_CFG_BASE     32'h0020_0000
`define MMIO_DEV_CLINT_BASE   32'h0030_0000
`define MMIO_DEV_BRIDGE_BASE  32'h0040_0000
`define MMIO_DEV_FIFO_BASE    32'h0050_0000

`endif

//--- mmio_bridge_pkg.sv
`include "mmio_bridge_settings.svh"
`default_nettype none

package mmio_bridge_pkg;

  ////////////////////////////////////////////////////////////
  // Processor bus
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0]
  {
    e_proc_rd
    , e_proc_wr
    , e_proc_amo
  } proc_msg_e;

  typedef enum logic [1:0]
  {
    e_amoadd
    , e_amoor
    , e_amoswap
  } proc_amo_e;

  typedef enum logic [1:0]
  {
    e_size_1
    , e_size_2
    , e_size_4
  } proc_size_e;

  // Network requester with x in the low bits
  typedef struct packed
  {
    logic [`MMIO_REG_ID_WIDTH-1:0] reg_id;
    logic [`MMIO_Y_WIDTH-1:0]      y;
    logic [`MMIO_X_WIDTH-1:0]      x;
  } proc_did_s;

  typedef struct packed
  {
    proc_msg_e                    msg_type;
    proc_amo_e                    subop;
    proc_size_e                   size;
    logic [`MMIO_PADDR_WIDTH-1:0] addr;
    proc_did_s                    did;
  } proc_header_s;

  ////////////////////////////////////////////////////////////
  // Mesh packets
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0]
  {
    e_net_load
    , e_net_store
    , e_net_amoadd
    , e_net_amoor
    , e_net_amoswap
  } net_op_e;

  typedef struct packed
  {
    logic       is_byte;
    logic       is_half;
    logic [1:0] part_sel;
  } net_load_info_s;

  typedef struct packed
  {
    net_op_e                        op;
    logic [`MMIO_EPA_WIDTH-1:0]     addr;
    logic [`MMIO_X_WIDTH-1:0]       x;
    logic [`MMIO_Y_WIDTH-1:0]       y;
    logic [`MMIO_X_WIDTH-1:0]       src_x;
    logic [`MMIO_Y_WIDTH-1:0]       src_y;
    logic [`MMIO_REG_ID_WIDTH-1:0]  reg_id;
    logic [`MMIO_DATA_WIDTH/8-1:0]  mask;
    net_load_info_s                 load_info;
    logic [`MMIO_DATA_WIDTH-1:0]    data;
  } net_packet_s;

  typedef enum logic
  {
    e_ret_credit
    , e_ret_data
  } net_return_type_e;

  typedef struct packed
  {
    net_return_type_e              ret_type;
    logic [`MMIO_DATA_WIDTH-1:0]   data;
    logic [`MMIO_X_WIDTH-1:0]      x;
    logic [`MMIO_Y_WIDTH-1:0]      y;
    logic [`MMIO_REG_ID_WIDTH-1:0] reg_id;
  } net_return_s;

  // Life of one reorder entry
  typedef enum logic [1:0]
  {
    e_rob_free
    , e_rob_pending
    , e_rob_returned
  } rob_state_e;

endpackage

`default_nettype wire

//--- outbound_request_encoder.sv
`include "mmio_bridge_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module outbound_request_encoder
  (input  mmio_bridge_pkg::proc_header_s        proc_fwd_header_i
   , input  logic [`MMIO_DATA_WIDTH-1:0]        proc_fwd_data_i
   , input  logic                               proc_fwd_v_i
   , input  logic [`MMIO_REG_ID_WIDTH-1:0]      trans_id_i

   , input  logic [`MMIO_X_WIDTH-1:0]           host_x_i
   , input  logic [`MMIO_Y_WIDTH-1:0]           host_y_i
   , input  logic [`MMIO_X_WIDTH-1:0]           global_x_i
   , input  logic [`MMIO_Y_WIDTH-1:0]           global_y_i

   , output mmio_bridge_pkg::net_packet_s       net_req_packet_o
   );

  import mmio_bridge_pkg::*;

  logic [`MMIO_PADDR_WIDTH-1:0]  addr;
  logic [1:0]                    region;
  logic                          is_tile;
  logic                          is_cache;
  logic [1:0]                    cache_row;
  logic [`MMIO_Y_WIDTH-1:0]      cache_y;
  logic [`MMIO_DATA_WIDTH/8-1:0] store_mask;

  assign addr   = proc_fwd_header_i.addr;
  assign region = addr[`MMIO_PADDR_WIDTH-1-:2];

  assign is_tile  = proc_fwd_v_i & (region == `MMIO_REGION_TILE);
  assign is_cache = proc_fwd_v_i & (region == `MMIO_REGION_CACHE);

  // Cache tiles sit on even rows; row field 0 is the bottom edge
  assign cache_row = addr[23:22];
  assign cache_y   = (cache_row == 2'b00) ? 4'hf : {1'b0, cache_row, 1'b0};

  always_comb
  begin
    case (proc_fwd_header_i.size)
      e_size_1: store_mask = 4'h1 << addr[1:0];
      e_size_2: store_mask = 4'h3 << addr[1:0];
      default:  store_mask = 4'hf << addr[1:0];
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Packet assembly
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    net_req_packet_o        = '0;
    net_req_packet_o.src_x  = global_x_i;
    net_req_packet_o.src_y  = global_y_i;
    net_req_packet_o.reg_id = trans_id_i;

    // Route by region
    if (is_tile)
    begin
      net_req_packet_o.addr = `MMIO_EPA_WIDTH'(addr[13:2]);
      net_req_packet_o.x    = addr[17:14];
      net_req_packet_o.y    = addr[21:18];
    end
    else if (is_cache)
    begin
      net_req_packet_o.addr = addr[17:2];
      net_req_packet_o.x    = addr[21:18];
      net_req_packet_o.y    = cache_y;
    end
    else
    begin
      net_req_packet_o.addr = addr[17:2];
      net_req_packet_o.x    = host_x_i;
      net_req_packet_o.y    = host_y_i;
    end

    case (proc_fwd_header_i.msg_type)
      e_proc_rd:
      begin
        net_req_packet_o.op                 = e_net_load;
        net_req_packet_o.load_info.is_byte  = (proc_fwd_header_i.size == e_size_1);
        net_req_packet_o.load_info.is_half  = (proc_fwd_header_i.size == e_size_2);
        net_req_packet_o.load_info.part_sel = addr[1:0];
      end
      e_proc_amo:
      begin
        net_req_packet_o.data = proc_fwd_data_i;
        case (proc_fwd_header_i.subop)
          e_amoadd: net_req_packet_o.op = e_net_amoadd;
          e_amoor:  net_req_packet_o.op = e_net_amoor;
          default:  net_req_packet_o.op = e_net_amoswap;
        endcase
      end
      default:
      begin
        net_req_packet_o.op   = e_net_store;
        net_req_packet_o.mask = store_mask;
        net_req_packet_o.data = proc_fwd_data_i;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- return_reorder_buffer.sv
`include "mmio_bridge_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module return_reorder_buffer
  #(parameter int unsigned depth_p = `MMIO_OUTSTANDING)
  (input  logic                                 clk_i
   , input  logic                               reset_i

   // One allocation per outbound request
   , input  logic                               alloc_yumi_i
   , input  mmio_bridge_pkg::proc_header_s      alloc_header_i
   , output logic [`MMIO_REG_ID_WIDTH-1:0]      alloc_id_o
   , output logic                               alloc_v_o

   // Returns from the mesh in any order
   , input  logic                               ret_v_i
   , input  mmio_bridge_pkg::net_return_s       ret_i

   // In-order release to the processor
   , output logic                               deq_v_o
   , output mmio_bridge_pkg::proc_header_s      deq_header_o
   , output logic [`MMIO_DATA_WIDTH-1:0]        deq_data_o
   , input  logic                               deq_yumi_i
   );

  import mmio_bridge_pkg::*;

  localparam int unsigned ptr_width_lp = (depth_p > 1) ? $clog2(depth_p) : 1;

  rob_state_e                  state_r    [depth_p];
  proc_header_s                header_mem [depth_p];
  logic [`MMIO_DATA_WIDTH-1:0] data_mem   [depth_p];

  logic [ptr_width_lp-1:0]     head_r;
  logic [ptr_width_lp-1:0]     tail_r;
  logic [ptr_width_lp-1:0]     ret_id;
  logic [`MMIO_DATA_WIDTH-1:0] ret_data;

  function automatic logic [ptr_width_lp-1:0] next_ptr
    (input logic [ptr_width_lp-1:0] ptr);
    next_ptr = (ptr == ptr_width_lp'(depth_p - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign ret_id = ret_i.reg_id[ptr_width_lp-1:0];

  // Store credits complete with zero data
  assign ret_data = (ret_i.ret_type == e_ret_credit) ? '0 : ret_i.data;

  assign alloc_v_o  = (state_r[tail_r] == e_rob_free);
  assign alloc_id_o = `MMIO_REG_ID_WIDTH'(tail_r);

  assign deq_v_o      = (state_r[head_r] == e_rob_returned);
  assign deq_header_o = header_mem[head_r];
  assign deq_data_o   = data_mem[head_r];

  ////////////////////////////////////////////////////////////
  // Entry state and pointers
  ////////////////////////////////////////////////////////////

  // Alloc, return and release always hit distinct entries
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < depth_p; i++)
      begin
        state_r[i] <= e_rob_free;
      end
      head_r <= '0;
      tail_r <= '0;
    end
    else
    begin
      if (alloc_yumi_i)
      begin
        state_r[tail_r] <= e_rob_pending;
        tail_r          <= next_ptr(tail_r);
      end
      if (ret_v_i)
      begin
        state_r[ret_id] <= e_rob_returned;
      end
      if (deq_yumi_i)
      begin
        state_r[head_r] <= e_rob_free;
        head_r          <= next_ptr(head_r);
      end
    end
  end

  // Payload storage
  always_ff @(posedge clk_i)
  begin
    if (alloc_yumi_i)
    begin
      header_mem[tail_r] <= alloc_header_i;
    end
    if (ret_v_i)
    begin
      data_mem[ret_id] <= ret_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Protocol checks
  ////////////////////////////////////////////////////////////

  // Mesh only answers IDs that were sent out and not yet answered
  a_ret_pending: assert property (@(posedge clk_i) disable iff (reset_i)
    ret_v_i |-> (state_r[ret_id] == e_rob_pending));

  // Bridge never issues a request without a free ID
  a_alloc_free: assert property (@(posedge clk_i) disable iff (reset_i)
    alloc_yumi_i |-> alloc_v_o);

  a_deq_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    deq_yumi_i |-> deq_v_o);

endmodule

`default_nettype wire

//--- inbound_request_mapper.sv
`include "mmio_bridge_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module inbound_request_mapper
  (input  mmio_bridge_pkg::net_packet_s         net_in_packet_i
   , input  logic                               net_in_v_i
   , output logic                               net_in_yumi_o

   , output mmio_bridge_pkg::proc_header_s      proc_fwd_header_o
   , output logic [`MMIO_DATA_WIDTH-1:0]        proc_fwd_data_o
   , output logic                               proc_fwd_v_o
   , input  logic                               proc_fwd_ready_and_i

   , input  mmio_bridge_pkg::proc_header_s      proc_rev_header_i
   , input  logic [`MMIO_DATA_WIDTH-1:0]        proc_rev_data_i
   , input  logic                               proc_rev_v_i
   , output logic                               proc_rev_ready_and_o

   , output mmio_bridge_pkg::net_return_s       net_ret_o
   , output logic                               net_ret_v_o
   );

  import mmio_bridge_pkg::*;

  logic [`MMIO_EPA_WIDTH-1:0]   byte_off;
  logic [3:0]                   dev;
  logic [`MMIO_PADDR_WIDTH-1:0] dev_base;

  // Word address to byte offset for aligned accesses
  assign byte_off = net_in_packet_i.addr << 2;
  assign dev      = byte_off[15:12];

  always_comb
  begin
    case (dev)
      4'h1:    dev_base = `MMIO_DEV_HOST_BASE;
      4'h2:    dev_base = `MMIO_DEV_CFG_BASE;
      4'h3:    dev_base = `MMIO_DEV_CLINT_BASE;
      4'h4:    dev_base = `MMIO_DEV_BRIDGE_BASE;
      4'h5:    dev_base = `MMIO_DEV_FIFO_BASE;
      // Bridge answers stray packets
      default: dev_base = `MMIO_DEV_BRIDGE_BASE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Mesh request to processor forward bus
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    proc_fwd_header_o            = '0;
    proc_fwd_header_o.msg_type   = (net_in_packet_i.op == e_net_load) ? e_proc_rd : e_proc_wr;
    proc_fwd_header_o.size       = e_size_4;
    proc_fwd_header_o.addr       = dev_base + `MMIO_PADDR_WIDTH'(byte_off[11:0]);
    proc_fwd_header_o.did.x      = net_in_packet_i.src_x;
    proc_fwd_header_o.did.y      = net_in_packet_i.src_y;
    proc_fwd_header_o.did.reg_id = net_in_packet_i.reg_id;
  end

  assign proc_fwd_data_o = net_in_packet_i.data;
  assign proc_fwd_v_o    = net_in_v_i;
  assign net_in_yumi_o   = proc_fwd_v_o & proc_fwd_ready_and_i;

  ////////////////////////////////////////////////////////////
  // Processor response to mesh return
  ////////////////////////////////////////////////////////////

  assign proc_rev_ready_and_o = 1'b1;
  assign net_ret_v_o          = proc_rev_v_i & proc_rev_ready_and_o;

  always_comb
  begin
    net_ret_o.ret_type = (proc_rev_header_i.msg_type == e_proc_wr) ? e_ret_credit : e_ret_data;
    net_ret_o.data     = proc_rev_data_i;
    net_ret_o.x        = proc_rev_header_i.did.x;
    net_ret_o.y        = proc_rev_header_i.did.y;
    net_ret_o.reg_id   = proc_rev_header_i.did.reg_id;
  end

endmodule

`default_nettype wire

//--- mmio_bridge.sv
`include "mmio_bridge_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module mmio_bridge
  (input  logic                                 clk_i
   , input  logic                               reset_i

   // Processor requests toward the mesh
   , input  mmio_bridge_pkg::proc_header_s      proc_fwd_header_i
   , input  logic [`MMIO_DATA_WIDTH-1:0]        proc_fwd_data_i
   , input  logic                               proc_fwd_v_i
   , output logic                               proc_fwd_ready_and_o

   , output mmio_bridge_pkg::proc_header_s      proc_rev_header_o
   , output logic [`MMIO_DATA_WIDTH-1:0]        proc_rev_data_o
   , output logic                               proc_rev_v_o
   , input  logic                               proc_rev_ready_and_i

   // Mesh requests toward the processor
   , output mmio_bridge_pkg::proc_header_s      proc_fwd_header_o
   , output logic [`MMIO_DATA_WIDTH-1:0]        proc_fwd_data_o
   , output logic                               proc_fwd_v_o
   , input  logic                               proc_fwd_ready_and_i

   , input  mmio_bridge_pkg::proc_header_s      proc_rev_header_i
   , input  logic [`MMIO_DATA_WIDTH-1:0]        proc_rev_data_i
   , input  logic                               proc_rev_v_i
   , output logic                               proc_rev_ready_and_o

   // Mesh endpoint packet ports
   , output mmio_bridge_pkg::net_packet_s       net_req_packet_o
   , output logic                               net_req_v_o
   , input  logic                               net_req_ready_i

   , input  mmio_bridge_pkg::net_return_s       net_ret_i
   , input  logic                               net_ret_v_i

   , input  mmio_bridge_pkg::net_packet_s       net_in_packet_i
   , input  logic                               net_in_v_i
   , output logic                               net_in_yumi_o

   , output mmio_bridge_pkg::net_return_s       net_ret_o
   , output logic                               net_ret_v_o

   , input  logic [`MMIO_X_WIDTH-1:0]           host_x_i
   , input  logic [`MMIO_Y_WIDTH-1:0]           host_y_i
   , input  logic [`MMIO_X_WIDTH-1:0]           global_x_i
   , input  logic [`MMIO_Y_WIDTH-1:0]           global_y_i
   );

  logic [`MMIO_REG_ID_WIDTH-1:0] trans_id;
  logic                          alloc_v;
  logic                          alloc_yumi;
  logic                          deq_yumi;

  // Request goes out only with a free ID and a ready endpoint
  assign proc_fwd_ready_and_o = alloc_v & net_req_ready_i;
  assign alloc_yumi           = proc_fwd_v_i & proc_fwd_ready_and_o;
  assign net_req_v_o          = alloc_yumi;
  assign deq_yumi             = proc_rev_v_o & proc_rev_ready_and_i;

  outbound_request_encoder u_encoder
    (.proc_fwd_header_i (proc_fwd_header_i)
     ,.proc_fwd_data_i  (proc_fwd_data_i)
     ,.proc_fwd_v_i     (proc_fwd_v_i)
     ,.trans_id_i       (trans_id)
     ,.host_x_i         (host_x_i)
     ,.host_y_i         (host_y_i)
     ,.global_x_i       (global_x_i)
     ,.global_y_i       (global_y_i)
     ,.net_req_packet_o (net_req_packet_o)
     );

  return_reorder_buffer #(.depth_p(`MMIO_OUTSTANDING)) u_rob
    (.clk_i           (clk_i)
     ,.reset_i        (reset_i)
     ,.alloc_yumi_i   (alloc_yumi)
     ,.alloc_header_i (proc_fwd_header_i)
     ,.alloc_id_o     (trans_id)
     ,.alloc_v_o      (alloc_v)
     ,.ret_v_i        (net_ret_v_i)
     ,.ret_i          (net_ret_i)
     ,.deq_v_o        (proc_rev_v_o)
     ,.deq_header_o   (proc_rev_header_o)
     ,.deq_data_o     (proc_rev_data_o)
     ,.deq_yumi_i     (deq_yumi)
     );

  inbound_request_mapper u_mapper
    (.net_in_packet_i       (net_in_packet_i)
     ,.net_in_v_i           (net_in_v_i)
     ,.net_in_yumi_o        (net_in_yumi_o)
     ,.proc_fwd_header_o    (proc_fwd_header_o)
     ,.proc_fwd_data_o      (proc_fwd_data_o)
     ,.proc_fwd_v_o         (proc_fwd_v_o)
     ,.proc_fwd_ready_and_i (proc_fwd_ready_and_i)
     ,.proc_rev_header_i    (proc_rev_header_i)
     ,.proc_rev_data_i      (proc_rev_data_i)
     ,.proc_rev_v_i         (proc_rev_v_i)
     ,.proc_rev_ready_and_o (proc_rev_ready_and_o)
     ,.net_ret_o            (net_ret_o)
     ,.net_ret_v_o          (net_ret_v_o)
     );

endmodule

`default_nettype wire

//--- tb_mmio_bridge.sv
`include "mmio_bridge_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module tb_mmio_bridge;

  import mmio_bridge_pkg::*;

  localparam int n_route     = 30;
  localparam int n_size      = 24;
  localparam int n_amo       = 12;
  localparam int n_order     = 40;
  localparam int n_capacity  = `MMIO_OUTSTANDING + 2;
  localparam int n_inbound   = 30;
  localparam int cycle_limit =
    (n_route + n_size + n_amo + n_order + n_capacity + n_inbound) * 40 + 200;

  localparam int mode_route    = 0;
  localparam int mode_size     = 1;
  localparam int mode_amo      = 2;
  localparam int mode_order    = 3;
  localparam int mode_capacity = 4;

  // Cycles with returns withheld in the capacity test
  localparam int hold_cycles = 20;

  logic                          clk_i;
  logic                          reset_i;
  proc_header_s                  proc_fwd_header_i;
  logic [`MMIO_DATA_WIDTH-1:0]   proc_fwd_data_i;
  logic                          proc_fwd_v_i;
  logic                          proc_fwd_ready_and_o;
  proc_header_s                  proc_rev_header_o;
  logic [`MMIO_DATA_WIDTH-1:0]   proc_rev_data_o;
  logic                          proc_rev_v_o;
  logic                          proc_rev_ready_and_i;
  proc_header_s                  proc_fwd_header_o;
  logic [`MMIO_DATA_WIDTH-1:0]   proc_fwd_data_o;
  logic                          proc_fwd_v_o;
  logic                          proc_fwd_ready_and_i;
  proc_header_s                  proc_rev_header_i;
  logic [`MMIO_DATA_WIDTH-1:0]   proc_rev_data_i;
  logic                          proc_rev_v_i;
  logic                          proc_rev_ready_and_o;
  net_packet_s                   net_req_packet_o;
  logic                          net_req_v_o;
  logic                          net_req_ready_i;
  net_return_s                   net_ret_i;
  logic                          net_ret_v_i;
  net_packet_s                   net_in_packet_i;
  logic                          net_in_v_i;
  logic                          net_in_yumi_o;
  net_return_s                   net_ret_o;
  logic                          net_ret_v_o;
  logic [`MMIO_X_WIDTH-1:0]      host_x_i;
  logic [`MMIO_Y_WIDTH-1:0]      host_y_i;
  logic [`MMIO_X_WIDTH-1:0]      global_x_i;
  logic [`MMIO_Y_WIDTH-1:0]      global_y_i;

  logic [31:0]  lcg_state   = 32'd60;
  int           error_count = 0;
  int           check_count = 0;
  int           test_count  = 0;
  int           cycle_count = 0;
  int           next_id     = 0;

  // Network model holds packets not yet answered
  net_packet_s  pend_q [$];
  // Processor model holds expected responses by request number
  proc_header_s seq_hdr  [0:63];
  logic [31:0]  seq_data [0:63];
  // Set once the DUT has taken the return for that request
  logic         seq_ret  [0:63];
  int           id_seq   [0:31];

  mmio_bridge u_dut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // Swap halves since the low LCG bits are weak
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  task automatic check_value(input string name, input logic [95:0] expected,
                             input logic [95:0] actual);
    check_count++;
    if (expected !== actual)
    begin
      error_count++;
      $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    test_count++;
    $display("test %-9s %s, %0d errors", name,
             (error_count == errors_before) ? "ok" : "FAILED", error_count - errors_before);
  endtask

  function automatic proc_header_s make_header(input int mode, input int idx);
    proc_header_s h;
    h          = '0;
    h.addr     = next_rand();
    h.did      = proc_did_s'(13'(next_rand()));
    h.msg_type = proc_msg_e'(2'(next_rand() % 3));
    h.size     = proc_size_e'(2'(next_rand() % 3));
    h.subop    = proc_amo_e'(2'(next_rand() % 3));
    case (mode)
      mode_route:
      begin
        case (idx % 3)
          0: h.addr[31:30] = 2'b11;
          1:
          begin
            h.addr[31:30] = 2'b10;
            // Bottom edge cache row
            if (idx % 2 == 1)
              h.addr[23:22] = 2'b00;
          end
          default: h.addr[31] = 1'b0;
        endcase
      end
      mode_size:
      begin
        h.msg_type  = (idx < 12) ? e_proc_rd : e_proc_wr;
        h.size      = proc_size_e'(2'((idx % 12) / 4));
        h.addr[1:0] = 2'(idx % 4);
      end
      mode_amo:
      begin
        h.msg_type = e_proc_amo;
        h.subop    = proc_amo_e'(2'(idx % 3));
      end
      default: ;
    endcase
    return h;
  endfunction

  // Expected mesh packet for one processor request
  function automatic net_packet_s model_packet(input proc_header_s h, input logic [31:0] d,
                                               input int id);
    net_packet_s p;
    int          nbytes;
    p        = '0;
    p.src_x  = global_x_i;
    p.src_y  = global_y_i;
    p.reg_id = 5'(id);
    nbytes   = (h.size == e_size_1) ? 1 : (h.size == e_size_2) ? 2 : 4;
    case (h.addr[31:30])
      2'b11:
      begin
        p.addr = {4'h0, h.addr[13:2]};
        p.x    = h.addr[17:14];
        p.y    = h.addr[21:18];
      end
      2'b10:
      begin
        p.addr = h.addr[17:2];
        p.x    = h.addr[21:18];
        p.y    = (h.addr[23:22] == 2'b00) ? 4'd15 : 4'(h.addr[23:22]) * 4'd2;
      end
      default:
      begin
        p.addr = h.addr[17:2];
        p.x    = host_x_i;
        p.y    = host_y_i;
      end
    endcase
    case (h.msg_type)
      e_proc_rd:
      begin
        p.op                 = e_net_load;
        p.load_info.is_byte  = (nbytes == 1);
        p.load_info.is_half  = (nbytes == 2);
        p.load_info.part_sel = h.addr[1:0];
      end
      e_proc_wr:
      begin
        p.op   = e_net_store;
        p.data = d;
        for (int b = 0; b < 4; b++)
          p.mask[b] = (b >= h.addr[1:0]) && (b < h.addr[1:0] + nbytes);
      end
      default:
      begin
        p.data = d;
        p.op   = (h.subop == e_amoadd) ? e_net_amoadd :
                 (h.subop == e_amoor)  ? e_net_amoor  : e_net_amoswap;
      end
    endcase
    return p;
  endfunction

  ////////////////////////////////////////////////////////////
  // Outbound traffic with network and processor models
  ////////////////////////////////////////////////////////////

  task automatic run_traffic(input string name, input int mode, input int count);
    net_packet_s pkt;
    net_return_s ret;
    int          issued;
    int          done;
    int          loop_cycle;
    int          idx;
    int          errs;
    logic        xfer;
    logic        deq;
    logic        hold;
    logic        exp_ready;
    errs       = error_count;
    issued     = 0;
    done       = 0;
    loop_cycle = 0;
    for (int i = 0; i < count; i++)
    begin
      seq_ret[i] = 1'b0;
    end
    while (done < count)
    begin
      @(negedge clk_i);
      xfer = proc_fwd_v_i && proc_fwd_ready_and_o;
      deq  = proc_rev_v_o && proc_rev_ready_and_i;
      hold = (mode == mode_capacity) && (loop_cycle < hold_cycles);
      // A free ID exists while fewer than the buffer depth are outstanding
      exp_ready = net_req_ready_i && (issued - done < `MMIO_OUTSTANDING);
      if (hold && issued == `MMIO_OUTSTANDING)
        check_value({name, " ready when full"}, 0, proc_fwd_ready_and_o);
      if (mode == mode_capacity && loop_cycle == hold_cycles)
        check_value({name, " accepted"}, `MMIO_OUTSTANDING, issued);
      check_value({name, " ready"}, exp_ready, proc_fwd_ready_and_o);
      check_value({name, " req_v"}, proc_fwd_v_i && exp_ready, net_req_v_o);
      check_value({name, " rev_v"}, seq_ret[done], proc_rev_v_o);
      // Return on the port now is taken at the next edge
      if (net_ret_v_i)
        seq_ret[id_seq[net_ret_i.reg_id]] = 1'b1;
      if (xfer)
      begin
        pkt = model_packet(proc_fwd_header_i, proc_fwd_data_i, next_id);
        check_value({name, " packet"}, pkt, net_req_packet_o);
        pend_q.push_back(net_req_packet_o);
        seq_hdr[issued] = proc_fwd_header_i;
        id_seq[next_id] = issued;
        next_id         = (next_id + 1) % `MMIO_OUTSTANDING;
        issued++;
      end
      if (deq)
      begin
        check_value({name, " rev header"}, seq_hdr[done], proc_rev_header_o);
        check_value({name, " rev data"}, seq_data[done], proc_rev_data_o);
        done++;
      end
      loop_cycle++;

      @(posedge clk_i);
      // Valid holds its request until accepted
      if (xfer || !proc_fwd_v_i)
      begin
        if (issued < count && (mode == mode_capacity || next_rand() % 4 != 0))
        begin
          proc_fwd_header_i <= make_header(mode, issued);
          proc_fwd_data_i   <= next_rand();
          proc_fwd_v_i      <= 1'b1;
        end
        else
          proc_fwd_v_i <= 1'b0;
      end
      net_req_ready_i      <= (mode == mode_capacity) || (next_rand() % 4 != 0);
      proc_rev_ready_and_i <= (mode == mode_capacity) || (next_rand() % 3 != 0);
      net_ret_v_i          <= 1'b0;
      if (!hold && pend_q.size() > 0 && next_rand() % 2 == 0)
      begin
        // Answer a random outstanding packet
        idx = next_rand() % pend_q.size();
        pkt = pend_q[idx];
        pend_q.delete(idx);
        ret.ret_type = (pkt.op == e_net_store) ? e_ret_credit : e_ret_data;
        ret.data     = next_rand();
        ret.x        = global_x_i;
        ret.y        = global_y_i;
        ret.reg_id   = pkt.reg_id;
        seq_data[id_seq[pkt.reg_id]] = (pkt.op == e_net_store) ? 32'h0 : ret.data;
        net_ret_i   <= ret;
        net_ret_v_i <= 1'b1;
      end
    end
    finish_test(name, errs);
  endtask

  ////////////////////////////////////////////////////////////
  // Inbound requests and processor responses
  ////////////////////////////////////////////////////////////

  task automatic run_inbound(input string name, input int count);
    net_packet_s  pkt;
    proc_header_s rev_hdr;
    proc_header_s exp_hdr;
    net_return_s  exp_ret;
    logic [3:0]   dev;
    logic [31:0]  base;
    logic         in_v;
    logic         fwd_ready;
    int           errs;
    errs = error_count;
    for (int i = 0; i < count; i++)
    begin
      pkt              = '0;
      pkt.op           = net_op_e'(3'(next_rand() % 5));
      pkt.addr         = 16'(next_rand());
      pkt.src_x        = 4'(next_rand());
      pkt.src_y        = 4'(next_rand());
      pkt.reg_id       = 5'(next_rand());
      pkt.data         = next_rand();
      rev_hdr          = '0;
      rev_hdr.msg_type = (next_rand() % 2 == 0) ? e_proc_rd : e_proc_wr;
      rev_hdr.addr     = next_rand();
      rev_hdr.did      = proc_did_s'(13'(next_rand()));
      in_v             = (next_rand() % 4 != 0);
      fwd_ready        = (next_rand() % 2 == 0);
      @(posedge clk_i);
      net_in_packet_i      <= pkt;
      net_in_v_i           <= in_v;
      proc_fwd_ready_and_i <= fwd_ready;
      proc_rev_header_i    <= rev_hdr;
      proc_rev_data_i      <= next_rand();
      proc_rev_v_i         <= (next_rand() % 2 == 0);
      @(negedge clk_i);
      // Byte offset bits 15:12 are word address bits 13:10
      dev  = pkt.addr[13:10];
      base = (dev >= 4'd1 && dev <= 4'd5) ? 32'h0010_0000 * dev : `MMIO_DEV_BRIDGE_BASE;
      exp_hdr            = '0;
      exp_hdr.msg_type   = (pkt.op == e_net_load) ? e_proc_rd : e_proc_wr;
      exp_hdr.size       = e_size_4;
      exp_hdr.addr       = base + {pkt.addr[9:0], 2'b00};
      exp_hdr.did.x      = pkt.src_x;
      exp_hdr.did.y      = pkt.src_y;
      exp_hdr.did.reg_id = pkt.reg_id;
      check_value({name, " fwd header"}, exp_hdr, proc_fwd_header_o);
      check_value({name, " fwd data"}, pkt.data, proc_fwd_data_o);
      check_value({name, " fwd_v"}, in_v, proc_fwd_v_o);
      check_value({name, " yumi"}, in_v && fwd_ready, net_in_yumi_o);
      exp_ret.ret_type = (rev_hdr.msg_type == e_proc_wr) ? e_ret_credit : e_ret_data;
      exp_ret.data     = proc_rev_data_i;
      exp_ret.x        = rev_hdr.did.x;
      exp_ret.y        = rev_hdr.did.y;
      exp_ret.reg_id   = rev_hdr.did.reg_id;
      check_value({name, " return"}, exp_ret, net_ret_o);
      check_value({name, " ret_v"}, proc_rev_v_i, net_ret_v_o);
      check_value({name, " rev ready"}, 1, proc_rev_ready_and_o);
    end
    @(posedge clk_i);
    net_in_v_i   <= 1'b0;
    proc_rev_v_i <= 1'b0;
    finish_test(name, errs);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    int errs;
    reset_i              = 1'b1;
    proc_fwd_header_i    = '0;
    proc_fwd_data_i      = '0;
    proc_fwd_v_i         = 1'b0;
    proc_rev_ready_and_i = 1'b1;
    proc_fwd_ready_and_i = 1'b0;
    proc_rev_header_i    = '0;
    proc_rev_data_i      = '0;
    proc_rev_v_i         = 1'b0;
    net_req_ready_i      = 1'b1;
    net_ret_i            = '0;
    net_ret_v_i          = 1'b0;
    net_in_packet_i      = '0;
    net_in_v_i           = 1'b0;
    host_x_i             = 4'd1;
    host_y_i             = 4'd0;
    global_x_i           = 4'd3;
    global_y_i           = 4'd5;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;

    @(negedge clk_i);
    errs = error_count;
    check_value("reset rev_v", 0, proc_rev_v_o);
    check_value("reset req_v", 0, net_req_v_o);
    check_value("reset ready", 1, proc_fwd_ready_and_o);
    finish_test("reset", errs);

    run_traffic("routing", mode_route, n_route);
    run_traffic("size", mode_size, n_size);
    run_traffic("atomic", mode_amo, n_amo);
    run_traffic("ordering", mode_order, n_order);
    run_traffic("capacity", mode_capacity, n_capacity);
    run_inbound("inbound", n_inbound);

    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
             error_count);
    if (error_count == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- mmio_bridge.f
+incdir+.
mmio_bridge_pkg.sv
outbound_request_encoder.sv
return_reorder_buffer.sv
inbound_request_mapper.sv
mmio_bridge.sv
tb_mmio_bridge.sv
